//--- source/audio_pkg.sv
package audio_pkg;

  // Sample and frame geometry
  localparam int sample_w   = 8;  // Unsigned ADC/DAC sample width
  localparam int frame_bits = 16; // Bit clock periods per I2S frame

  // Unsigned midpoint of a sample, also the silence level
  localparam logic [sample_w-1:0] centre = 8'd128;

  // Effect select codes, code 3 is unused
  typedef enum logic [1:0] {
    fx_bypass = 2'd0, // Sample passes unchanged
    fx_gate   = 2'd1, // Noise gate around centre
    fx_echo   = 2'd2  // Mix with a delayed sample
  } effect_e;

  // Mic side sample, rx to effect and effect to volume
  typedef struct packed {
    logic [sample_w-1:0] sample; // Unsigned, centre is silence
  } mic_sample_t;

  // Speaker side sample, volume to tx
  typedef struct packed {
    logic                muted;  // Word produced under mute
    logic [sample_w-1:0] sample; // Unsigned, offset restored
  } spk_sample_t;

  // Frame layout
  //   bits 0..7   ws low, sample MSB first
  //   bits 8..15  ws high, ignored on input, zero on output
  // Word select is the top bit of the 4-bit bit counter

  // Stage links carry struct + valid + ready
  // Transfer happens when valid and ready are high together
  // Upstream holds data steady until it is taken

  // Centred arithmetic in the effect and volume stages uses
  // sample - centre as a signed value one bit wider than a sample

endpackage

//--- source/clk_divider.sv
`timescale 1ns/1ns

module clk_divider #(
  parameter int div_count = 7 // Half period of bclk in hwclk cycles
) (
  input  logic hwclk,
  input  logic rst_n,
  output logic bclk,      // Divided serial bit clock
  output logic bclk_rise, // One hwclk cycle, bclk just went high
  output logic bclk_fall  // One hwclk cycle, bclk just went low
);

  localparam int cnt_w = (div_count > 1) ? $clog2(div_count) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(div_count - 1);

  logic [cnt_w-1:0] cnt; // hwclk cycles into this half period
  logic             tick; // Last cycle of the half period

  assign tick = (cnt == cnt_last);

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      cnt       <= '0;
      bclk      <= 1'b0; // Idle low, first toggle is a rise
      bclk_rise <= 1'b0;
      bclk_fall <= 1'b0;
    end else begin
      bclk_rise <= 1'b0; // Strobes last one cycle only
      bclk_fall <= 1'b0;
      if (tick) begin
        cnt       <= '0;
        bclk      <= ~bclk;
        bclk_rise <= ~bclk; // Aligned with the new bclk level
        bclk_fall <= bclk;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // High half of bclk lasts div_count hwclk cycles
  a_half_period: assert property (@(posedge hwclk) disable iff (!rst_n)
    bclk_rise |-> ##div_count bclk_fall);

endmodule

//--- source/i2s_receiver.sv
`timescale 1ns/1ns

module i2s_receiver import audio_pkg::*; (
  input  logic        hwclk,
  input  logic        rst_n,
  input  logic        bclk_rise,     // Sample point for adc data
  input  logic        bclk_fall,     // Bit boundary, ws changes here
  input  logic        adc_serial_in, // From mic ADC, MSB first
  input  logic        out_ready,
  output logic        ws,            // Word select to the ADC
  output mic_sample_t out_data,
  output logic        out_valid,
  output logic        overrun        // Sticky, a sample was lost
);

  localparam int cnt_w = $clog2(frame_bits);

  logic [cnt_w-1:0]    bit_cnt;   // Bit index within frame
  logic [sample_w-2:0] shift_q;   // First seven sample bits
  logic                frame_end; // Rise that samples the last bit
  logic                in_word;   // Bits 0..7 of the frame

  assign in_word   = (bit_cnt < cnt_w'(sample_w));
  assign frame_end = bclk_rise && (bit_cnt == cnt_w'(sample_w - 1));
  assign ws        = bit_cnt[cnt_w-1]; // High for the second half

  // Frame position, advances on each falling edge
  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (bclk_fall) begin
      bit_cnt <= bit_cnt + 1'b1; // Wraps at frame_bits
    end
  end

  // Serial capture
  always_ff @(posedge hwclk) begin
    if (bclk_rise && in_word) begin
      shift_q <= {shift_q[sample_w-3:0], adc_serial_in};
    end
  end

  // Output buffer, newest frame wins
  always_ff @(posedge hwclk) begin
    if (frame_end) begin
      out_data.sample <= {shift_q, adc_serial_in}; // Full word
    end
  end

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      if (frame_end) begin
        out_valid <= 1'b1; // Visible one cycle after the rise
        if (out_valid && !out_ready) begin
          overrun <= 1'b1; // Old word replaced before it was taken
        end
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Held word stays offered, and only moves when overrun flags the loss
  a_hold_data: assert property (@(posedge hwclk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && ($stable(out_data) || overrun)));

endmodule

//--- source/audio_effect.sv
`timescale 1ns/1ns

module audio_effect import audio_pkg::*; #(
  parameter int gate_level = 12, // Gate threshold around centre
  parameter int echo_depth = 8   // Echo delay in accepted samples
) (
  input  logic        hwclk,
  input  logic        rst_n,
  input  effect_e     effect,    // Sampled on acceptance
  input  mic_sample_t in_data,
  input  logic        in_valid,
  input  logic        out_ready,
  output logic        in_ready,
  output mic_sample_t out_data,
  output logic        out_valid
);

  localparam int ptr_w = (echo_depth > 1) ? $clog2(echo_depth) : 1;
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(echo_depth - 1);

  logic [sample_w-1:0]       dline [echo_depth]; // Circular delay line
  logic [ptr_w-1:0]          wr_ptr;  // Oldest entry, overwritten next
  logic                      primed;  // Delay line has wrapped once
  logic [sample_w-1:0]       old_s;   // Sample echo_depth back
  logic                      accept;
  logic signed [sample_w:0]   cur_c;  // Current sample, centred
  logic signed [sample_w:0]   old_c;  // Delayed sample, centred
  logic        [sample_w:0]   cur_mag; // Distance from centre
  logic signed [sample_w+1:0] echo_sum;
  logic signed [sample_w+1:0] echo_half;
  logic [sample_w-1:0]       fx_out;  // Result for this sample

  assign in_ready = !out_valid || out_ready; // Empty or draining
  assign accept   = in_valid && in_ready;

  // Unwritten entries read back as silence
  assign old_s = primed ? dline[wr_ptr] : centre;

  always_comb begin
    cur_c     = $signed({1'b0, in_data.sample}) - $signed({1'b0, centre});
    old_c     = $signed({1'b0, old_s}) - $signed({1'b0, centre});
    cur_mag   = (cur_c < 0) ? -cur_c : cur_c;
    echo_sum  = cur_c + old_c;    // Range -256..254
    echo_half = echo_sum >>> 1;   // Back into sample range
    case (effect)
      fx_gate: begin
        if (cur_mag < gate_level) begin
          fx_out = centre; // Inside the band, squelch
        end else begin
          fx_out = in_data.sample;
        end
      end
      fx_echo: fx_out = echo_half[sample_w-1:0] + centre; // Restore offset
      default: fx_out = in_data.sample; // Bypass
    endcase
  end

  // Delay line, fed in every mode
  always_ff @(posedge hwclk) begin
    if (accept) begin
      dline[wr_ptr] <= in_data.sample;
    end
  end

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      primed <= 1'b0;
    end else if (accept) begin
      if (wr_ptr == ptr_last) begin
        wr_ptr <= '0;
        primed <= 1'b1; // Every entry now holds a real sample
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Output register
  always_ff @(posedge hwclk) begin
    if (accept) begin
      out_data.sample <= fx_out;
    end
  end

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Code 3 is never driven from the top
  a_effect_code: assert property (@(posedge hwclk) disable iff (!rst_n)
    accept |-> effect inside {fx_bypass, fx_gate, fx_echo});

endmodule

//--- source/volume_shifter.sv
`timescale 1ns/1ns

module volume_shifter import audio_pkg::*; (
  input  logic        hwclk,
  input  logic        rst_n,
  input  logic [1:0]  volume,   // 3 is full scale
  input  logic        mute,
  input  mic_sample_t in_data,
  input  logic        in_valid,
  input  logic        out_ready,
  output logic        in_ready,
  output spk_sample_t out_data,
  output logic        out_valid
);

  logic                     accept;
  logic [1:0]               shamt;   // Attenuation as a right shift
  logic signed [sample_w:0] cur_c;   // Centred input
  logic signed [sample_w:0] scaled;  // Centred, attenuated
  logic [sample_w-1:0]      vol_out; // Offset restored

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;
  assign shamt    = 2'd3 - volume;

  always_comb begin
    cur_c  = $signed({1'b0, in_data.sample}) - $signed({1'b0, centre});
    scaled = cur_c >>> shamt; // Keeps sign for negative values
    if (mute) begin
      vol_out = centre; // Silence
    end else begin
      vol_out = scaled[sample_w-1:0] + centre;
    end
  end

  // Output register, controls captured with the sample
  always_ff @(posedge hwclk) begin
    if (accept) begin
      out_data.sample <= vol_out;
      out_data.muted  <= mute; // Drives tx standby
    end
  end

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

//--- source/i2s_transmitter.sv
`timescale 1ns/1ns

module i2s_transmitter import audio_pkg::*; (
  input  logic        hwclk,
  input  logic        rst_n,
  input  logic        bclk,           // Shared bit clock
  input  logic        bclk_fall,      // Bit boundary for DAC data
  input  logic        dac_en,         // Low puts the DAC in standby
  input  spk_sample_t in_data,
  input  logic        in_valid,
  output logic        in_ready,       // One cycle per frame at most
  output logic        dac_serial_out, // MSB first
  output logic        ws_out,
  output logic        bclk_out,
  output logic        standby
);

  localparam int cnt_w = $clog2(frame_bits);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(frame_bits - 1);

  logic [cnt_w-1:0]    bit_cnt;  // Bit currently on the line
  logic [cnt_w-1:0]    next_cnt;
  logic [sample_w-2:0] shift_q;  // Bits still to send
  logic                ws_q;
  logic                muted_q;  // Word on the line was muted
  logic                load;     // Fall that opens bit 0
  spk_sample_t         word;     // Sample taken this frame

  assign next_cnt = bit_cnt + 1'b1;
  assign load     = bclk_fall && (bit_cnt == cnt_last);
  assign in_ready = load && dac_en; // No pull during standby

  // Silence when nothing is waiting
  assign word = (in_valid && in_ready) ? in_data : '{muted: 1'b0, sample: centre};

  // DAC side gating
  assign bclk_out = bclk && dac_en;
  assign ws_out   = ws_q && dac_en;
  assign standby  = !dac_en || muted_q;

  always_ff @(posedge hwclk) begin
    if (!rst_n) begin
      bit_cnt        <= cnt_last; // First fall starts a frame
      ws_q           <= 1'b0;
      dac_serial_out <= 1'b0;
      muted_q        <= 1'b0;
    end else if (bclk_fall) begin
      bit_cnt <= next_cnt;
      ws_q    <= next_cnt[cnt_w-1]; // High for bits 8..15
      if (load) begin
        dac_serial_out <= word.sample[sample_w-1];
        muted_q        <= word.muted;
      end else if (next_cnt < cnt_w'(sample_w)) begin
        dac_serial_out <= shift_q[sample_w-2]; // Next bit down
      end else begin
        dac_serial_out <= 1'b0; // Pad half of the frame
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (load) begin
      shift_q <= word.sample[sample_w-2:0];
    end else if (bclk_fall) begin
      shift_q <= {shift_q[sample_w-3:0], 1'b0};
    end
  end

  // Waiting word stays put until the frame boundary pulls it
  a_in_hold: assert property (@(posedge hwclk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

//--- source/walkie_audio_top.sv
`timescale 1ns/1ns

module walkie_audio_top import audio_pkg::*; #(
  parameter int div_count  = 7,  // bclk half period in hwclk cycles
  parameter int gate_level = 12, // Noise gate threshold
  parameter int echo_depth = 8   // Echo delay in samples
) (
  input  logic       hwclk,
  input  logic       rst_n,
  input  logic       adc_serial_in,  // From mic ADC
  input  effect_e    effect,         // Effect select
  input  logic [1:0] volume,
  input  logic       mute,
  input  logic       dac_en,         // Speaker DAC enable
  output logic       ws,             // Word select to mic ADC
  output logic       dac_serial_out, // To speaker DAC
  output logic       ws_out,         // Word select to DAC
  output logic       bclk_out,       // Gated bit clock to DAC
  output logic       standby,        // DAC standby request
  output logic       overrun         // Sticky sample loss flag
);

  logic bclk, bclk_rise, bclk_fall; // Shared serial timing

  mic_sample_t rx_to_fx_data;  // Receiver to effect
  logic        rx_to_fx_valid, rx_to_fx_ready;
  mic_sample_t fx_to_vol_data; // Effect to volume
  logic        fx_to_vol_valid, fx_to_vol_ready;
  spk_sample_t vol_to_tx_data; // Volume to transmitter
  logic        vol_to_tx_valid, vol_to_tx_ready;

  clk_divider #(.div_count(div_count)) u_div (
    .hwclk(hwclk), .rst_n(rst_n),
    .bclk(bclk), .bclk_rise(bclk_rise), .bclk_fall(bclk_fall));

  i2s_receiver u_rx (
    .hwclk(hwclk), .rst_n(rst_n), // From top
    .bclk_rise(bclk_rise), .bclk_fall(bclk_fall), // From divider
    .adc_serial_in(adc_serial_in), .out_ready(rx_to_fx_ready),
    .ws(ws), .out_data(rx_to_fx_data), .out_valid(rx_to_fx_valid),
    .overrun(overrun));

  audio_effect #(.gate_level(gate_level), .echo_depth(echo_depth)) u_fx (
    .hwclk(hwclk), .rst_n(rst_n), .effect(effect),
    .in_data(rx_to_fx_data), .in_valid(rx_to_fx_valid), .in_ready(rx_to_fx_ready),
    .out_data(fx_to_vol_data), .out_valid(fx_to_vol_valid), .out_ready(fx_to_vol_ready));

  volume_shifter u_vol (
    .hwclk(hwclk), .rst_n(rst_n), .volume(volume), .mute(mute),
    .in_data(fx_to_vol_data), .in_valid(fx_to_vol_valid), .in_ready(fx_to_vol_ready),
    .out_data(vol_to_tx_data), .out_valid(vol_to_tx_valid), .out_ready(vol_to_tx_ready));

  i2s_transmitter u_tx (
    .hwclk(hwclk), .rst_n(rst_n), // From top
    .bclk(bclk), .bclk_fall(bclk_fall), .dac_en(dac_en), // Same divider as rx
    .in_data(vol_to_tx_data), .in_valid(vol_to_tx_valid), .in_ready(vol_to_tx_ready),
    .dac_serial_out(dac_serial_out), .ws_out(ws_out), .bclk_out(bclk_out),
    .standby(standby)); // To DAC

endmodule

//--- dv/tb_walkie_audio.sv
`timescale 1ns/1ns

module tb_walkie_audio import audio_pkg::*; ();

  localparam int div_count    = 7;
  localparam int gate_level   = 12;
  localparam int echo_depth   = 8;
  localparam int bit_cycles   = 2 * div_count;          // hwclk cycles per bclk period
  localparam int frame_cycles = bit_cycles * frame_bits; // hwclk cycles per frame

  logic       hwclk;
  logic       rst_n;
  logic       adc_serial_in;
  effect_e    effect;
  logic [1:0] volume;
  logic       mute;
  logic       dac_en;
  logic       ws;
  logic       dac_serial_out;
  logic       ws_out;
  logic       bclk_out;
  logic       standby;
  logic       overrun;

  integer     seed;
  int         errors;
  int         checks;
  int         timeouts;
  int         cyc;          // hwclk edges since reset release
  int         frames_sent;  // ADC frames started in this segment
  int         got_cnt;      // DAC words compared in this segment
  int         stim_kind;    // 0 uniform, 1 mix around the gate band
  logic [7:0] cur_sample;   // Word on the ADC line
  logic [7:0] exp_q[$];     // Expected DAC words, oldest first
  int         echo_hist[echo_depth]; // Centred input history
  int         echo_pos;     // Oldest history entry
  logic       armed;        // Decoder has seen a ws_out high half
  int         nbits;
  logic [7:0] dac_word;

  walkie_audio_top #(
    .div_count(div_count), .gate_level(gate_level), .echo_depth(echo_depth)
  ) DUT (
    .hwclk(hwclk), .rst_n(rst_n), .adc_serial_in(adc_serial_in),
    .effect(effect), .volume(volume), .mute(mute), .dac_en(dac_en),
    .ws(ws), .dac_serial_out(dac_serial_out), .ws_out(ws_out),
    .bclk_out(bclk_out), .standby(standby), .overrun(overrun)
  );

  initial begin
    hwclk = 1'b0;
    forever #10 hwclk = ~hwclk; // 20 ns period
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic [7:0] next_sample();
    int r;
    r = $random(seed);
    if (stim_kind == 1 && r[16]) begin
      r = 128 + (r % gate_level); // Lands inside the band
    end
    if (r[7:0] == 8'd128) begin
      r = 129; // Keep clear of the midpoint
    end
    return r[7:0];
  endfunction

  // Reference model, effect then volume on centred values
  task automatic push_expected(input logic [7:0] s);
    int c;
    int old;
    int fx;
    int v;
    c   = int'(s) - 128;
    old = echo_hist[echo_pos]; // Sample echo_depth back
    echo_hist[echo_pos] = c;
    echo_pos = (echo_pos + 1) % echo_depth;
    case (effect)
      fx_gate: fx = (((c < 0) ? -c : c) < gate_level) ? 0 : c;
      fx_echo: fx = (c + old) >>> 1; // Arithmetic half
      default: fx = c;
    endcase
    v = mute ? 0 : (fx >>> (3 - int'(volume)));
    exp_q.push_back(8'(v + 128));
  endtask

  task automatic take_word(input logic [7:0] w);
    if (exp_q.size() == 0) begin
      errors++;
      $display("DAC word 0x%0h arrived with no sample waiting for it", w);
    end else begin
      check_eq("dac_word", w, exp_q.pop_front());
      check_eq("standby", standby, mute); // Muted words request standby
      got_cnt++;
    end
  endtask

  // ADC model, new bit each time the divider raises bclk
  always @(posedge hwclk) begin
    int bit_no;
    int junk;
    if (!rst_n) begin
      cyc = 0;
    end else begin
      cyc++;
      if (cyc % bit_cycles == div_count) begin // bclk_rise strobe set on this edge
        bit_no = ((cyc - div_count) / bit_cycles) % frame_bits;
        if (bit_no == 0) begin
          cur_sample = next_sample();
          push_expected(cur_sample);
          frames_sent++;
        end
        junk = $random(seed);
        #1;
        check_eq("ws", ws, bit_no >= sample_w); // Frame position agrees
        if (bit_no < sample_w) begin
          adc_serial_in = cur_sample[sample_w-1-bit_no]; // MSB first
        end else begin
          adc_serial_in = junk[0]; // Ignored half
        end
      end
    end
  end

  // DAC decoder
  always @(posedge bclk_out) begin
    if (ws_out) begin
      armed = 1'b1; // Frame alignment known from here
      nbits = 0;
    end else if (armed) begin
      dac_word = {dac_word[6:0], dac_serial_out};
      nbits++;
      if (nbits == sample_w) begin
        take_word(dac_word);
        nbits = 0;
      end
    end
  end

  // Controls only move while reset is held
  task automatic start_segment(input effect_e fx, input logic [1:0] vol,
                               input logic mt, input logic en, input int kind);
    int i;
    @(posedge hwclk);
    #1;
    rst_n  = 1'b0;
    effect = fx;
    volume = vol;
    mute   = mt;
    dac_en = en;
    stim_kind = kind;
    exp_q.delete();
    for (i = 0; i < echo_depth; i++) begin
      echo_hist[i] = 0; // Delay line reads silence
    end
    echo_pos    = 0;
    frames_sent = 0;
    got_cnt     = 0;
    repeat (4) @(posedge hwclk);
    armed       = 1'b0; // bclk_out parked low by reset
    nbits       = 0;
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_words(input int n);
    int t;
    t = 0;
    while (got_cnt < n && t < (n + 3) * frame_cycles) begin
      @(posedge hwclk);
      #1;
      t++;
    end
    if (got_cnt < n) begin
      timeouts++;
      $display("Timeout: only %0d of %0d DAC words arrived", got_cnt, n);
    end
  endtask

  task automatic run_stream(input effect_e fx, input logic [1:0] vol,
                            input logic mt, input int n, input int kind);
    start_segment(fx, vol, mt, 1'b1, kind);
    wait_words(n);
    check_eq("overrun", overrun, 1'b0); // Rates match, nothing lost
  endtask

  // DAC disabled, pipeline backs up into the receiver
  task automatic run_standby(input int n);
    int t;
    start_segment(fx_bypass, 2'd3, 1'b0, 1'b0, 0);
    t = 0;
    while (frames_sent <= n && t < (n + 2) * frame_cycles) begin
      @(posedge hwclk);
      #1;
      t++;
      check_eq("bclk_out", bclk_out, 1'b0);
      check_eq("ws_out", ws_out, 1'b0);
    end
    if (frames_sent <= n) begin
      timeouts++;
      $display("Timeout: only %0d ADC frames ran with the DAC disabled", frames_sent);
    end
    check_eq("overrun", overrun, 1'b1);
    check_eq("standby", standby, 1'b1);
  endtask

  initial begin
    seed          = 32'hc885c2b5;
    errors        = 0;
    checks        = 0;
    timeouts      = 0;
    rst_n         = 1'b0;
    adc_serial_in = 1'b0;
    effect        = fx_bypass;
    volume        = 2'd3;
    mute          = 1'b0;
    dac_en        = 1'b1;
    cyc           = 0;
    frames_sent   = 0;
    got_cnt       = 0;
    stim_kind     = 0;
    cur_sample    = 8'd129;
    echo_pos      = 0;
    armed         = 1'b0;
    nbits         = 0;
    dac_word      = 8'd0;

    run_stream(fx_bypass, 2'd3, 1'b0, 64, 0); // Straight through
    run_stream(fx_gate,   2'd3, 1'b0, 64, 1); // Squelch near centre
    run_stream(fx_echo,   2'd3, 1'b0, 40, 0); // Mix with delay line
    run_stream(fx_bypass, 2'd0, 1'b0, 24, 0);
    run_stream(fx_bypass, 2'd1, 1'b0, 24, 0);
    run_stream(fx_bypass, 2'd2, 1'b0, 24, 0);
    run_stream(fx_bypass, 2'd3, 1'b1, 24, 0); // Mute, all silence
    run_standby(6);
    run_stream(fx_bypass, 2'd3, 1'b0, 24, 0); // Overrun cleared by reset

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- walkie_audio_top.f
source/audio_pkg.sv
source/clk_divider.sv
source/i2s_receiver.sv
source/audio_effect.sv
source/volume_shifter.sv
source/i2s_transmitter.sv
source/walkie_audio_top.sv
dv/tb_walkie_audio.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The simulation output is shown and searched for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_walkie_audio \
  -f walkie_audio_top.f \
  -o sim_walkie_audio &&
./obj_dir/sim_walkie_audio | tee /dev/stderr | grep -q "PASS: all tests" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
